//--- hdl/overlord_params.svh
// Overlord spy bus constants
`ifndef OVERLORD_PARAMS_SVH
`define OVERLORD_PARAMS_SVH

////////////////////
// Widths
`define SPY_DW        16
`define UPC_W         14

`define SCRATCH_RESET 16'h1234

////////////////////
// Write addresses
`define SPY_SCRATCH1  3'd0
`define SPY_SCRATCH2  3'd1
`define SPY_MODE      3'd2
`define SPY_OPC       3'd3
`define SPY_CLK       3'd4
`define SPY_STATLIM   3'd5

// Read addresses
// Scratch reads back at its own write slots
`define SPY_STATUS    3'd2
`define SPY_UPC       3'd4
`define SPY_STATCNT   3'd5
`define SPY_OPCREG    3'd7

`endif

//--- hdl/spy_pkg.sv
// Spy bus types
`default_nettype none
`include "overlord_params.svh"

package spy_pkg;

   typedef logic [`SPY_DW-1:0] spy_word_t;
   typedef logic [2:0]         spy_adr_t;
   typedef logic [`UPC_W-1:0]  upc_t;

   ////////////////////
   // Bus request and response
   typedef struct packed {
      logic      cyc;
      logic      stb;
      logic      we;
      spy_adr_t  adr;
      spy_word_t dat;
   } spy_wb_req_t;

   typedef struct packed {
      logic      ack;
      spy_word_t dat;
   } spy_wb_rsp_t;

   // One-cycle load strobes with the write word
   typedef struct packed {
      logic      ldscratch;
      logic      ldmode;
      logic      ldopc;
      logic      ldclk;
      logic      ldstatlim;
      spy_word_t wdat;
   } spy_ld_t;

   typedef struct packed {
      logic opcinh;
      logic opcclk;
      logic lpc_hold;
   } opc_ctl_t;

   // Listed MSB first, so machrun lands on bit 0 of the status word
   typedef struct packed {
      logic stathenb;
      logic stathalt;
      logic promdisabled;
      logic errstop;
      logic sstep;
      logic ssdone;
      logic srun;
      logic machrun;
   } olord_status_t;

   typedef enum logic [1:0] {
      CYC_FETCH,
      CYC_DECODE,
      CYC_EXEC,
      CYC_WRITE
   } cyc_state_t;

endpackage

`default_nettype wire

//--- hdl/spy_port.sv
// Spy bus slave port
`timescale 1ns/10ps
`default_nettype none
`include "overlord_params.svh"

module spy_port
   import spy_pkg::*;
(
   input  wire clk,
   input  wire reset,
   input  wire spy_wb_req_t   wb_req,
   output spy_wb_rsp_t        wb_rsp,
   output spy_ld_t            ld,
   input  wire spy_word_t     scratch,
   input  wire olord_status_t status,
   input  wire upc_t          upc,
   input  wire upc_t          opc,
   input  wire spy_word_t     stat_count
);

   logic      ack;
   logic      req;
   logic      wr_go;
   logic      rd_go;
   spy_word_t rd_mux;
   spy_word_t rdat;

   // A cycle is taken only while ack is low, so ack lasts one clock
   assign req   = wb_req.cyc & wb_req.stb & ~ack;
   assign wr_go = req & wb_req.we;
   assign rd_go = req & ~wb_req.we;

   always_ff @(posedge clk) begin
      if (reset) begin
         ack <= 1'b0;
      end else begin
         ack <= req;
      end
   end

   ////////////////////
   // Write decode with strobes landing on the ack edge
   always_comb begin
      ld      = '0;
      ld.wdat = wb_req.dat;
      if (wr_go) begin
         case (wb_req.adr)
            `SPY_SCRATCH1, `SPY_SCRATCH2: ld.ldscratch = 1'b1;
            `SPY_MODE:    ld.ldmode = 1'b1;
            `SPY_OPC:     ld.ldopc = 1'b1;
            `SPY_CLK:     ld.ldclk = 1'b1;
            `SPY_STATLIM: ld.ldstatlim = 1'b1;
            default:      ;
         endcase
      end
   end

   ////////////////////
   // Read select
   always_comb begin
      case (wb_req.adr)
         `SPY_SCRATCH1, `SPY_SCRATCH2: rd_mux = scratch;
         `SPY_STATUS:  rd_mux = {{(`SPY_DW - $bits(olord_status_t)){1'b0}}, status};
         `SPY_UPC:     rd_mux = {{(`SPY_DW - `UPC_W){1'b0}}, upc};
         `SPY_STATCNT: rd_mux = stat_count;
         `SPY_OPCREG:  rd_mux = {{(`SPY_DW - `UPC_W){1'b0}}, opc};
         default:      rd_mux = '0;
      endcase
   end

   // Read word is captured together with ack
   always_ff @(posedge clk) begin
      if (rd_go) begin
         rdat <= rd_mux;
      end
   end

   assign wb_rsp = '{ack: ack, dat: rdat};

endmodule

`default_nettype wire

//--- hdl/olord_regs.sv
// Overlord console registers
`timescale 1ns/10ps
`default_nettype none
`include "overlord_params.svh"

module olord_regs
   import spy_pkg::*;
(
   input  wire clk,
   input  wire reset,
   input  wire spy_ld_t ld,
   input  wire boot,
   input  wire errhalt,
   input  wire waiting,
   input  wire set_promdisable,
   input  wire state_fetch,
   input  wire statstop,
   output spy_word_t     scratch,
   output opc_ctl_t      opc_ctl,
   output olord_status_t status,
   output logic promdisable,
   output logic idebug,
   output logic nop11
);

   logic stathenb;
   logic errstop;
   logic promdisabled;
   logic run;
   logic step;
   logic srun;
   logic sstep;
   logic ssdone;
   logic stathalt;
   logic machrun;

   ////////////////////
   // Mode register
   // Trap enable (bit 4) has no trap logic to feed in this block
   always_ff @(posedge clk) begin
      if (reset) begin
         promdisable <= 1'b0;
         stathenb    <= 1'b0;
         errstop     <= 1'b0;
      end else if (ld.ldmode) begin
         promdisable <= ld.wdat[5];
         stathenb    <= ld.wdat[3];
         errstop     <= ld.wdat[2];
      end else if (set_promdisable) begin
         promdisable <= 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         scratch <= `SCRATCH_RESET;
      end else if (ld.ldscratch) begin
         scratch <= ld.wdat;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         opc_ctl <= '0;
      end else if (ld.ldopc) begin
         opc_ctl <= '{opcinh: ld.wdat[2], opcclk: ld.wdat[1], lpc_hold: ld.wdat[0]};
      end
   end

   ////////////////////
   // Clock control without the stat-load bit
   always_ff @(posedge clk) begin
      if (reset) begin
         idebug <= 1'b0;
         nop11  <= 1'b0;
         step   <= 1'b0;
      end else if (ld.ldclk) begin
         idebug <= ld.wdat[3];
         nop11  <= ld.wdat[2];
         step   <= ld.wdat[1];
      end
   end

   // Boot wins over a host write
   always_ff @(posedge clk) begin
      if (reset) begin
         run <= 1'b0;
      end else if (boot) begin
         run <= 1'b1;
      end else if (ld.ldclk) begin
         run <= ld.wdat[0];
      end
   end

   // Step rising edge rearms ssdone and the next fetch sets it again
   always_ff @(posedge clk) begin
      if (reset) begin
         srun         <= 1'b0;
         sstep        <= 1'b0;
         ssdone       <= 1'b0;
         promdisabled <= 1'b0;
      end else begin
         srun         <= run;
         sstep        <= step;
         promdisabled <= promdisable;
         if (!sstep && step) begin
            ssdone <= 1'b0;
         end
         if (state_fetch) begin
            ssdone <= sstep;
         end
      end
   end

   assign stathalt = statstop & stathenb;
   assign machrun  = (sstep & ~ssdone) | (srun & ~errhalt & ~waiting & ~stathalt);

   always_comb begin
      status              = '0;
      status.machrun      = machrun;
      status.srun         = srun;
      status.ssdone       = ssdone;
      status.sstep        = sstep;
      status.errstop      = errstop;
      status.promdisabled = promdisabled;
      status.stathalt     = stathalt;
      status.stathenb     = stathenb;
   end

endmodule

`default_nettype wire

//--- hdl/cycle_sequencer.sv
// Micro-cycle sequencer
`timescale 1ns/10ps
`default_nettype none

module cycle_sequencer
   import spy_pkg::*;
(
   input  wire clk,
   input  wire reset,
   input  wire machrun,
   input  wire opc_ctl_t opc_ctl,
   output logic state_fetch,
   output upc_t upc,
   output upc_t opc
);

   cyc_state_t state;
   cyc_state_t state_nxt;
   logic       opcclk_q;
   logic       opcclk_rise;

   always_comb begin
      case (state)
         CYC_FETCH:  state_nxt = CYC_DECODE;
         CYC_DECODE: state_nxt = CYC_EXEC;
         CYC_EXEC:   state_nxt = CYC_WRITE;
         default:    state_nxt = CYC_FETCH;
      endcase
   end

   // Machine freezes in place while machrun is low
   always_ff @(posedge clk) begin
      if (reset) begin
         state <= CYC_FETCH;
      end else if (machrun) begin
         state <= state_nxt;
      end
   end

   assign state_fetch = machrun & (state == CYC_FETCH);
   assign opcclk_rise = opc_ctl.opcclk & ~opcclk_q;

   ////////////////////
   // Micro PC and old PC
   always_ff @(posedge clk) begin
      if (reset) begin
         upc      <= '0;
         opc      <= '0;
         opcclk_q <= 1'b0;
      end else begin
         opcclk_q <= opc_ctl.opcclk;
         if (state_fetch && !opc_ctl.lpc_hold) begin
            upc <= upc + upc_t'(1);
         end
         // Manual opcclk edge captures even with opcinh set
         if ((state_fetch && !opc_ctl.opcinh) || opcclk_rise) begin
            opc <= upc;
         end
      end
   end

endmodule

`default_nettype wire

//--- hdl/stat_counter.sv
// Statistics fetch counter
`timescale 1ns/10ps
`default_nettype none

module stat_counter
   import spy_pkg::*;
(
   input  wire clk,
   input  wire reset,
   input  wire spy_ld_t ld,
   input  wire state_fetch,
   output spy_word_t stat_count,
   output logic statstop
);

   spy_word_t limit;

   always_ff @(posedge clk) begin
      if (reset) begin
         limit <= '0;
      end else if (ld.ldstatlim) begin
         limit <= ld.wdat;
      end
   end

   // Loading a new limit restarts the count
   always_ff @(posedge clk) begin
      if (reset) begin
         stat_count <= '0;
      end else if (ld.ldstatlim) begin
         stat_count <= '0;
      end else if (state_fetch) begin
         stat_count <= stat_count + spy_word_t'(1);
      end
   end

   // Zero limit means no stop
   assign statstop = (stat_count == limit) && (limit != '0);

endmodule

`default_nettype wire

//--- hdl/overlord_top.sv
// Overlord console block top
`timescale 1ns/10ps
`default_nettype none

module overlord_top
   import spy_pkg::*;
(
   input  wire clk,
   input  wire reset,
   input  wire spy_wb_req_t wb_req,
   output spy_wb_rsp_t      wb_rsp,
   input  wire boot,
   input  wire errhalt,
   input  wire waiting,
   input  wire set_promdisable,
   output logic promdisable,
   output logic idebug,
   output logic nop11,
   output logic errstop,
   output logic machrun
);

   spy_ld_t       ld;
   spy_word_t     scratch;
   olord_status_t status;
   opc_ctl_t      opc_ctl;
   upc_t          upc;
   upc_t          opc;
   spy_word_t     stat_count;
   logic          state_fetch;
   logic          statstop;

   spy_port spy_port_i (
      .clk        (clk),
      .reset      (reset),
      .wb_req     (wb_req),
      .wb_rsp     (wb_rsp),
      .ld         (ld),
      .scratch    (scratch),
      .status     (status),
      .upc        (upc),
      .opc        (opc),
      .stat_count (stat_count)
   );

   olord_regs olord_regs_i (
      .clk             (clk),
      .reset           (reset),
      .ld              (ld),
      .boot            (boot),
      .errhalt         (errhalt),
      .waiting         (waiting),
      .set_promdisable (set_promdisable),
      .state_fetch     (state_fetch),
      .statstop        (statstop),
      .scratch         (scratch),
      .opc_ctl         (opc_ctl),
      .status          (status),
      .promdisable     (promdisable),
      .idebug          (idebug),
      .nop11           (nop11)
   );

   cycle_sequencer cycle_sequencer_i (
      .clk         (clk),
      .reset       (reset),
      .machrun     (status.machrun),
      .opc_ctl     (opc_ctl),
      .state_fetch (state_fetch),
      .upc         (upc),
      .opc         (opc)
   );

   stat_counter stat_counter_i (
      .clk         (clk),
      .reset       (reset),
      .ld          (ld),
      .state_fetch (state_fetch),
      .stat_count  (stat_count),
      .statstop    (statstop)
   );

   // Status bits brought out to the console
   assign errstop = status.errstop;
   assign machrun = status.machrun;

endmodule

`default_nettype wire

//--- test/tb_overlord.sv
// Overlord console block testbench
`timescale 1ns/10ps
`default_nettype none
`include "overlord_params.svh"

module tb_overlord
   import spy_pkg::*;
();

   localparam int MAX_PAT   = 128;
   localparam int ACK_LIMIT = 4;
   localparam int RUN_LIMIT = 64;

   // Pattern operations
   localparam logic [15:0] OP_WRITE  = 16'h1;
   localparam logic [15:0] OP_READ   = 16'h2;
   localparam logic [15:0] OP_INPUTS = 16'h3;
   localparam logic [15:0] OP_IDLE   = 16'h4;
   localparam logic [15:0] OP_PORTS  = 16'h5;
   localparam logic [15:0] OP_WAIT   = 16'h6;
   localparam logic [15:0] OP_RESET  = 16'h8;

   logic        clk = 1'b0;
   logic        reset;
   spy_wb_req_t wb_req;
   spy_wb_rsp_t wb_rsp;
   logic        boot;
   logic        errhalt;
   logic        waiting;
   logic        set_promdisable;
   logic        promdisable;
   logic        idebug;
   logic        nop11;
   logic        errstop;
   logic        machrun;
   logic [15:0] port_word;

   // Four words per command (op, address, data, expected)
   logic [`SPY_DW-1:0] pat_mem [0:4*MAX_PAT-1];
   logic [15:0]        pat_op;
   logic [15:0]        pat_adr;
   logic [15:0]        pat_data;
   logic [15:0]        pat_exp;
   spy_word_t          rd_word;
   int                 num_pat;
   int                 cycle_count = 0;
   int                 cycle_limit = 0;

   always #10 clk = ~clk;

   overlord_top overlord_top_i (
      .clk             (clk),
      .reset           (reset),
      .wb_req          (wb_req),
      .wb_rsp          (wb_rsp),
      .boot            (boot),
      .errhalt         (errhalt),
      .waiting         (waiting),
      .set_promdisable (set_promdisable),
      .promdisable     (promdisable),
      .idebug          (idebug),
      .nop11           (nop11),
      .errstop         (errstop),
      .machrun         (machrun)
   );

   // Console outputs packed from bit 0 up
   assign port_word = {11'd0, nop11, idebug, machrun, errstop, promdisable};

   ////////////////////
   // Failure handling
   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("=== FAIL ===");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
      if (got !== exp) begin
         abort_run($sformatf("Mismatch at time %0t: %s got %h, expected %h",
                             $time, name, got, exp));
      end
   endtask

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count > cycle_limit) begin
         abort_run($sformatf("Timeout after %0d cycles, the run never finished",
                             cycle_count));
      end
   end

   function automatic string read_name(input spy_adr_t adr);
      case (adr)
         `SPY_SCRATCH1, `SPY_SCRATCH2: return "scratch";
         `SPY_STATUS:  return "status";
         `SPY_UPC:     return "upc";
         `SPY_STATCNT: return "stat_count";
         `SPY_OPCREG:  return "opc";
         default:      return "rd_dat";
      endcase
   endfunction

   ////////////////////
   // Bus and machine helpers
   task automatic bus_cycle(input logic we, input spy_adr_t adr, input spy_word_t wdat,
                            output spy_word_t rdat);
      int waited;
      waited = 0;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      wb_req.we  = we;
      wb_req.adr = adr;
      wb_req.dat = wdat;
      while (!wb_rsp.ack && waited < ACK_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!wb_rsp.ack) begin
         abort_run($sformatf("No ack from the spy port for address %0d", adr));
      end else begin
         rdat   = wb_rsp.dat;
         wb_req = '0;
         // One idle cycle before the next request
         @(negedge clk);
      end
   endtask

   task automatic drive_inputs(input logic [3:0] levels);
      boot            = levels[0];
      errhalt         = levels[1];
      waiting         = levels[2];
      set_promdisable = levels[3];
      @(negedge clk);
   endtask

   // Machine must start, then stop on its own
   task automatic wait_for_stop();
      int waited;
      waited = 0;
      while (!machrun && waited < RUN_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!machrun) begin
         abort_run("The machine never started running");
      end else begin
         waited = 0;
         while (machrun && waited < RUN_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (machrun) begin
            abort_run("The machine kept running and never stopped");
         end else begin
            @(negedge clk);
         end
      end
   endtask

   task automatic apply_reset();
      reset  = 1'b1;
      wb_req = '0;
      repeat (5) @(negedge clk);
      reset = 1'b0;
   endtask

   ////////////////////
   // Pattern player
   initial begin
      reset           = 1'b1;
      wb_req          = '0;
      boot            = 1'b0;
      errhalt         = 1'b0;
      waiting         = 1'b0;
      set_promdisable = 1'b0;
      $readmemh("test/overlord_patterns.txt", pat_mem);
      num_pat = 0;
      while (num_pat < MAX_PAT && pat_mem[4*num_pat] != '0) begin
         num_pat++;
      end
      if (num_pat == 0) begin
         abort_run("The pattern file is missing or holds no commands");
      end
      cycle_limit = 64 * num_pat + 100;
      apply_reset();
      for (int i = 0; i < num_pat; i++) begin
         pat_op   = pat_mem[4*i];
         pat_adr  = pat_mem[4*i+1];
         pat_data = pat_mem[4*i+2];
         pat_exp  = pat_mem[4*i+3];
         case (pat_op)
            OP_WRITE: bus_cycle(1'b1, pat_adr[2:0], pat_data, rd_word);
            OP_READ: begin
               bus_cycle(1'b0, pat_adr[2:0], 16'h0000, rd_word);
               check_value(read_name(pat_adr[2:0]), rd_word, pat_exp);
            end
            OP_INPUTS: drive_inputs(pat_data[3:0]);
            OP_IDLE:   repeat (pat_data) @(negedge clk);
            OP_PORTS:  check_value("console ports", port_word, pat_exp);
            OP_WAIT:   wait_for_stop();
            OP_RESET:  apply_reset();
            default: begin
               abort_run($sformatf("Unknown operation %h in command %0d", pat_op, i));
            end
         endcase
      end
      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

//--- test/overlord_patterns.txt
// op adr data expected, all hex, op 0 ends the list
// op 1 write, 2 read and compare, 3 inputs, 4 idle, 5 ports, 6 wait for stop, 8 reset
// inputs bit0 boot, bit1 errhalt, bit2 waiting, bit3 set_promdisable
// ports bit0 promdisable, bit1 errstop, bit2 machrun, bit3 idebug, bit4 nop11
// scratch through both addresses
2 0 0000 1234
2 1 0000 1234
1 1 beef 0000
2 0 0000 beef
2 1 0000 beef
1 0 5a5a 0000
2 1 0000 5a5a
// mode register and set_promdisable
1 2 002c 0000
2 2 0000 00b0
5 0 0000 0003
1 2 0000 0000
2 2 0000 0000
5 0 0000 0000
3 0 0008 0000
3 0 0000 0000
5 0 0000 0001
2 2 0000 0020
1 2 0000 0000
// debug and no-op bits, then single steps
1 4 000c 0000
5 0 0000 0018
1 4 0000 0000
1 4 0002 0000
6 0 0000 0000
2 4 0000 0001
2 2 0000 000c
2 7 0000 0000
1 4 0000 0000
1 4 0002 0000
6 0 0000 0000
2 4 0000 0002
2 7 0000 0001
1 4 0000 0000
1 4 0002 0000
6 0 0000 0000
2 4 0000 0003
2 7 0000 0002
// opcinh holds opc, opcclk edge loads it
1 3 0004 0000
1 4 0000 0000
1 4 0002 0000
6 0 0000 0000
2 4 0000 0004
2 7 0000 0002
1 3 0006 0000
2 7 0000 0004
1 3 0001 0000
// free run with lpc_hold, then waiting and errhalt
1 4 0000 0000
1 4 0001 0000
4 0 0008 0000
5 0 0000 0004
2 2 0000 0003
2 4 0000 0004
3 0 0004 0000
5 0 0000 0000
1 3 0000 0000
4 0 0004 0000
2 4 0000 0004
3 0 0002 0000
4 0 0004 0000
2 4 0000 0004
2 2 0000 0002
1 4 0000 0000
3 0 0000 0000
2 4 0000 0004
// statistics stop after a boot run
8 0 0000 0000
2 0 0000 1234
2 4 0000 0000
1 2 0008 0000
1 5 0003 0000
3 0 0001 0000
6 0 0000 0000
2 4 0000 0003
2 5 0000 0003
2 2 0000 00c2
5 0 0000 0000
3 0 0000 0000
1 4 0000 0000
1 5 0000 0000
2 5 0000 0000
2 2 0000 0080
0 0 0000 0000

//--- vlog.f
+incdir+hdl
hdl/spy_pkg.sv
hdl/spy_port.sv
hdl/olord_regs.sv
hdl/cycle_sequencer.sv
hdl/stat_counter.sv
hdl/overlord_top.sv
test/tb_overlord.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the overlord testbench with Verilator from the project root
cd "$(dirname "$0")" \
   && verilator --binary --timing --timescale 1ns/10ps \
      --top-module tb_overlord -f vlog.f -Mdir obj_dir -o tb_overlord \
   && ./obj_dir/tb_overlord \
   || { echo "overlord simulation did not pass"; exit 1; }
